// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the receive path testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --top-module tb_nic_rx --Mdir "$BUILD" -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/Vtb_nic_rx" > "$LOG" 2>&1
status=$?
cat "$LOG"

# The log decides the verdict
if grep -q "Checks failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0

// ==== src.f ====
+incdir+include
src/nic_pkg.sv
src/rx_frame_writer.sv
src/rx_buffer.sv
src/rx_frame_counters.sv
src/rx_host_port.sv
src/nic_rx_top.sv
tb/tb_nic_rx.sv

// ==== src/nic_pkg.sv ====
package nic_pkg;

    //--------------------------------------------------
    // Widths with a meaning
    //--------------------------------------------------
    typedef logic [63:0] qword_t;              // One MAC / buffer data word
    typedef logic [7:0]  byte_valid_t;         // Valid byte lanes of a quadword
    typedef logic [31:0] frame_count_t;        // Frame counter value
    typedef logic [3:0]  reg_addr_t;           // Wishbone register address

    //--------------------------------------------------
    // Bundles
    //--------------------------------------------------
    typedef struct packed {
        qword_t      data;                     // Receive quadword
        byte_valid_t data_valid;               // Any bit set marks a data cycle
        logic        good_frame;               // End of frame, FCS ok
        logic        bad_frame;                // End of frame, errored
    } mac_rx_t;

    typedef struct packed {
        logic committed;                       // Good frame made visible
        logic rejected;                        // Bad frame rewound
        logic dropped;                         // Frame lost to a full buffer
    } rx_event_t;

    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        reg_addr_t adr;
        qword_t    dat;
    } wb_req_t;

    typedef struct packed {
        logic   ack;
        qword_t dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {st_idle, st_frame, st_drop} rx_state_t;

    //--------------------------------------------------
    // Register map
    //--------------------------------------------------
    localparam reg_addr_t REG_WR_PTR = 4'd0;   // Committed write pointer
    localparam reg_addr_t REG_RD_PTR = 4'd1;   // Committed read pointer
    localparam reg_addr_t REG_AVAIL  = 4'd2;   // Quadwords ready, capped
    localparam reg_addr_t REG_GOOD   = 4'd3;
    localparam reg_addr_t REG_BAD    = 4'd4;
    localparam reg_addr_t REG_DROP   = 4'd5;
    localparam reg_addr_t REG_DATA   = 4'd6;   // Pop one quadword

endpackage

// ==== src/nic_rx_top.sv ====
module nic_rx_top #(
    parameter int BUF_AW       = 6,            // 64 slots, 63 usable
    parameter int BURST_QWORDS = 16            // Cap on the available count
) (
    input  logic              xaui_clk_156_25_out,
    input  logic              reset_n,
    input  nic_pkg::mac_rx_t  mac_rx,          // MAC receive stream, no stall
    input  nic_pkg::wb_req_t  wb_req,
    output nic_pkg::wb_rsp_t  wb_rsp,
    output logic              rx_ready         // Data waiting for the host
);

    //--------------------------------------------------
    // Buffer write side
    //--------------------------------------------------
    logic [BUF_AW-1:0]     wr_addr;
    nic_pkg::qword_t       wr_data;
    logic                  wr_en;
    logic [BUF_AW-1:0]     wr_ptr;             // Committed write pointer

    //--------------------------------------------------
    // Buffer read side
    //--------------------------------------------------
    logic [BUF_AW-1:0]     rd_addr;
    nic_pkg::qword_t       rd_data;
    logic [BUF_AW-1:0]     rd_ptr;             // Committed read pointer

    nic_pkg::rx_event_t    rx_event;           // Frame outcome pulses
    nic_pkg::frame_count_t good_count;
    nic_pkg::frame_count_t bad_count;
    nic_pkg::frame_count_t drop_count;

    rx_frame_writer #(.BUF_AW(BUF_AW)) u_writer (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .mac_rx              (mac_rx),
        .rd_ptr              (rd_ptr),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .wr_en               (wr_en),
        .wr_ptr              (wr_ptr),
        .rx_event            (rx_event)
    );

    rx_buffer #(.BUF_AW(BUF_AW)) u_buffer (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .wr_en               (wr_en),
        .rd_addr             (rd_addr),
        .rd_data             (rd_data)
    );

    rx_frame_counters u_counters (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .rx_event            (rx_event),
        .good_count          (good_count),
        .bad_count           (bad_count),
        .drop_count          (drop_count)
    );

    rx_host_port #(.BUF_AW(BUF_AW), .BURST_QWORDS(BURST_QWORDS)) u_host (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .wb_req              (wb_req),
        .wb_rsp              (wb_rsp),
        .wr_ptr              (wr_ptr),
        .rd_ptr              (rd_ptr),
        .rd_addr             (rd_addr),
        .rd_data             (rd_data),
        .good_count          (good_count),
        .bad_count           (bad_count),
        .drop_count          (drop_count),
        .rx_ready            (rx_ready)
    );

endmodule

// ==== src/rx_buffer.sv ====
module rx_buffer #(
    parameter int BUF_AW = 6
) (
    input  logic              xaui_clk_156_25_out,
    input  logic [BUF_AW-1:0] wr_addr,
    input  nic_pkg::qword_t   wr_data,
    input  logic              wr_en,
    input  logic [BUF_AW-1:0] rd_addr,
    output nic_pkg::qword_t   rd_data          // One cycle after rd_addr
);

    localparam int DEPTH = 2 ** BUF_AW;

    nic_pkg::qword_t mem [DEPTH];              // Ring storage

    // Write port
    always_ff @(posedge xaui_clk_156_25_out) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read port
    always_ff @(posedge xaui_clk_156_25_out) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== src/rx_frame_counters.sv ====
module rx_frame_counters (
    input  logic                  xaui_clk_156_25_out,
    input  logic                  reset_n,
    input  nic_pkg::rx_event_t    rx_event,
    output nic_pkg::frame_count_t good_count,
    output nic_pkg::frame_count_t bad_count,
    output nic_pkg::frame_count_t drop_count
);

    // Stick at all ones
    function automatic nic_pkg::frame_count_t sat_inc(input nic_pkg::frame_count_t cnt);
        return (cnt == '1) ? cnt : cnt + 1'b1;
    endfunction

    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            good_count <= '0;
            bad_count  <= '0;
            drop_count <= '0;
        end else begin
            if (rx_event.committed) begin
                good_count <= sat_inc(good_count);
            end
            if (rx_event.rejected) begin
                bad_count <= sat_inc(bad_count);
            end
            if (rx_event.dropped) begin
                drop_count <= sat_inc(drop_count);
            end
        end
    end

    // Every frame has exactly one outcome
    a_one_event: assert property (
        @(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        $onehot0(rx_event)
    );

endmodule

// ==== src/rx_frame_writer.sv ====
module rx_frame_writer #(
    parameter int BUF_AW = 6
) (
    input  logic                      xaui_clk_156_25_out,
    input  logic                      reset_n,
    input  nic_pkg::mac_rx_t          mac_rx,
    input  logic [BUF_AW-1:0]         rd_ptr,      // Host side committed pointer
    output logic [BUF_AW-1:0]         wr_addr,
    output nic_pkg::qword_t           wr_data,
    output logic                      wr_en,
    output logic [BUF_AW-1:0]         wr_ptr,      // Last committed frame end
    output nic_pkg::rx_event_t        rx_event
);

    nic_pkg::rx_state_t state;
    logic [BUF_AW-1:0]  run_addr;                  // Next slot of the current frame
    logic [BUF_AW-1:0]  next_addr;
    logic               data_cycle;
    logic               frame_end;
    logic               full;

    //--------------------------------------------------
    // Datapath
    //--------------------------------------------------
    assign data_cycle = |mac_rx.data_valid;        // Partial quadwords stored whole
    assign frame_end  = mac_rx.good_frame | mac_rx.bad_frame;
    assign next_addr  = run_addr + 1'b1;
    assign full       = (next_addr == rd_ptr);     // One slot kept free

    assign wr_addr = run_addr;
    assign wr_data = mac_rx.data;
    assign wr_en   = data_cycle & ~full & (state != nic_pkg::st_drop);

    //--------------------------------------------------
    // Frame FSM
    //--------------------------------------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            state    <= nic_pkg::st_idle;
            run_addr <= '0;
            wr_ptr   <= '0;
            rx_event <= '0;
        end else begin
            rx_event <= '0;                        // Pulses last one cycle
            case (state)
                nic_pkg::st_idle,
                nic_pkg::st_frame: begin
                    if (frame_end) begin
                        state <= nic_pkg::st_idle;
                        if (mac_rx.good_frame) begin
                            wr_ptr             <= run_addr;  // Publish frame
                            rx_event.committed <= 1'b1;
                        end else begin
                            run_addr          <= wr_ptr;    // Forget frame
                            rx_event.rejected <= 1'b1;
                        end
                    end else if (data_cycle) begin
                        if (full) begin
                            state <= nic_pkg::st_drop;      // No room, lose the rest
                        end else begin
                            run_addr <= next_addr;
                            state    <= nic_pkg::st_frame;
                        end
                    end
                end
                nic_pkg::st_drop: begin
                    if (frame_end) begin                 // Status does not matter
                        run_addr         <= wr_ptr;
                        rx_event.dropped <= 1'b1;
                        state            <= nic_pkg::st_idle;
                    end
                end
                default: begin
                    state <= nic_pkg::st_idle;
                end
            endcase
        end
    end

    //--------------------------------------------------
    // Checks
    //--------------------------------------------------
    // An open frame never wraps its running address onto unread host data
    a_no_overrun: assert property (
        @(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        (state == nic_pkg::st_frame) |-> (run_addr != rd_ptr)
    );

endmodule

// ==== src/rx_host_port.sv ====
module rx_host_port #(
    parameter int BUF_AW       = 6,
    parameter int BURST_QWORDS = 16
) (
    input  logic                  xaui_clk_156_25_out,
    input  logic                  reset_n,
    input  nic_pkg::wb_req_t      wb_req,
    output nic_pkg::wb_rsp_t      wb_rsp,
    input  logic [BUF_AW-1:0]     wr_ptr,
    output logic [BUF_AW-1:0]     rd_ptr,
    output logic [BUF_AW-1:0]     rd_addr,
    input  nic_pkg::qword_t       rd_data,
    input  nic_pkg::frame_count_t good_count,
    input  nic_pkg::frame_count_t bad_count,
    input  nic_pkg::frame_count_t drop_count,
    output logic                  rx_ready
);

    logic              ack_q;
    nic_pkg::qword_t   dat_q;
    logic              pop_pend;               // REG_DATA waiting on the RAM
    logic              pop_ok;                 // Buffer held data at request
    logic              req_new;
    logic              req_pop;
    logic [BUF_AW-1:0] fill;
    nic_pkg::qword_t   avail;
    nic_pkg::qword_t   reg_rdata;

    //--------------------------------------------------
    // Status
    //--------------------------------------------------
    assign fill     = wr_ptr - rd_ptr;         // Wraps with the ring
    assign avail    = (nic_pkg::qword_t'(fill) > nic_pkg::qword_t'(BURST_QWORDS)) ?
                      nic_pkg::qword_t'(BURST_QWORDS) : nic_pkg::qword_t'(fill);
    assign rx_ready = (wr_ptr != rd_ptr);
    assign rd_addr  = rd_ptr;                  // Head quadword always on the read port

    assign req_new = wb_req.cyc & wb_req.stb & ~ack_q & ~pop_pend;
    assign req_pop = req_new & ~wb_req.we & (wb_req.adr == nic_pkg::REG_DATA);

    // Register map
    always_comb begin
        case (wb_req.adr)
            nic_pkg::REG_WR_PTR: reg_rdata = nic_pkg::qword_t'(wr_ptr);
            nic_pkg::REG_RD_PTR: reg_rdata = nic_pkg::qword_t'(rd_ptr);
            nic_pkg::REG_AVAIL:  reg_rdata = avail;
            nic_pkg::REG_GOOD:   reg_rdata = nic_pkg::qword_t'(good_count);
            nic_pkg::REG_BAD:    reg_rdata = nic_pkg::qword_t'(bad_count);
            nic_pkg::REG_DROP:   reg_rdata = nic_pkg::qword_t'(drop_count);
            default:             reg_rdata = '0;
        endcase
    end

    //--------------------------------------------------
    // Bus sequencing
    //--------------------------------------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            ack_q    <= 1'b0;
            pop_pend <= 1'b0;
            pop_ok   <= 1'b0;
            rd_ptr   <= '0;
        end else begin
            ack_q <= 1'b0;
            if (pop_pend) begin
                ack_q    <= 1'b1;              // Second cycle of a pop
                pop_pend <= 1'b0;
                if (pop_ok) begin
                    rd_ptr <= rd_ptr + 1'b1;   // Free the slot with the ack
                end
            end else if (req_pop) begin
                pop_pend <= 1'b1;
                pop_ok   <= rx_ready;
            end else if (req_new) begin
                ack_q <= 1'b1;                 // Register read or ignored write
            end
        end
    end

    // Response data
    always_ff @(posedge xaui_clk_156_25_out) begin
        if (pop_pend) begin
            dat_q <= pop_ok ? rd_data : '0;    // Empty pop reads zero
        end else if (req_new) begin
            dat_q <= wb_req.we ? '0 : reg_rdata;
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: dat_q};

    // Classic cycle: ack only inside an active strobe
    a_ack_in_cycle: assert property (
        @(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        ack_q |-> wb_req.cyc && wb_req.stb
    );

endmodule

// ==== include/tb_nic_rx_tasks.svh ====
`ifndef TB_NIC_RX_TASKS_SVH
`define TB_NIC_RX_TASKS_SVH

    //--------------------------------------------------
    // Reference model
    //--------------------------------------------------
    nic_pkg::qword_t model_q[$];               // Quadwords the host can still pop
    int model_wr   = 0;
    int model_rd   = 0;
    int model_good = 0;
    int model_bad  = 0;
    int model_drop = 0;

    // Expected outcome of one frame, model state updated
    function automatic nic_pkg::rx_event_t model_frame(input nic_pkg::qword_t data[$],
                                                       input bit good);
        nic_pkg::rx_event_t ev;
        ev = '0;
        if (data.size() > (1 << BUF_AW) - 1 - model_q.size()) begin
            ev.dropped = 1'b1;                 // Fills up first, status ignored
            model_drop++;
        end else if (good) begin
            ev.committed = 1'b1;
            foreach (data[i]) model_q.push_back(data[i]);
            model_wr = (model_wr + data.size()) % (1 << BUF_AW);
            model_good++;
        end else begin
            ev.rejected = 1'b1;
            model_bad++;
        end
        return ev;
    endfunction

    task automatic check_value(input string what, input nic_pkg::qword_t expected,
                               input nic_pkg::qword_t actual);
        assert (actual == expected) else begin
            $display("Fail %s %s: expected 0x%h actual 0x%h", test_name, what, expected, actual);
            stop_with_failure();
        end
    endtask

    //--------------------------------------------------
    // Bus and MAC drivers
    //--------------------------------------------------
    task automatic wb_cycle(input bit we, input nic_pkg::reg_addr_t adr,
                            input nic_pkg::qword_t wdat, output nic_pkg::qword_t rdat);
        int waited;
        waited = 0;
        @(posedge xaui_clk_156_25_out);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(posedge xaui_clk_156_25_out);
            waited++;
            assert (waited <= ACK_LIMIT) else begin
                $display("Timeout: no Wishbone ack for address %0d", adr);
                stop_with_failure();
            end
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        wb_req <= '0;                          // Strobe drops after the ack
    endtask

    task automatic expect_reg(input nic_pkg::reg_addr_t adr, input int expected,
                              input string what);
        nic_pkg::qword_t dat;
        wb_cycle(1'b0, adr, '0, dat);
        check_value(what, nic_pkg::qword_t'(expected), dat);
    endtask

    // Whole register map and rx_ready against the model
    task automatic expect_state();
        int avail;
        avail = (model_q.size() > BURST_QWORDS) ? BURST_QWORDS : model_q.size();
        expect_reg(nic_pkg::REG_WR_PTR, model_wr, "REG_WR_PTR");
        expect_reg(nic_pkg::REG_RD_PTR, model_rd, "REG_RD_PTR");
        expect_reg(nic_pkg::REG_AVAIL, avail, "REG_AVAIL");
        expect_reg(nic_pkg::REG_GOOD, model_good, "REG_GOOD");
        expect_reg(nic_pkg::REG_BAD, model_bad, "REG_BAD");
        expect_reg(nic_pkg::REG_DROP, model_drop, "REG_DROP");
        check_value("rx_ready", nic_pkg::qword_t'(model_q.size() != 0),
                    nic_pkg::qword_t'(rx_ready));
    endtask

    task automatic pop_and_check();
        nic_pkg::qword_t dat;
        nic_pkg::qword_t expected;
        expected = '0;                         // Empty pop reads zero
        if (model_q.size() != 0) begin
            expected = model_q.pop_front();
            model_rd = (model_rd + 1) % (1 << BUF_AW);
        end
        wb_cycle(1'b0, nic_pkg::REG_DATA, '0, dat);
        check_value("REG_DATA", expected, dat);
    endtask

    task automatic send_frame(input int len, input bit good, output nic_pkg::qword_t data[$]);
        nic_pkg::byte_valid_t valid;
        data = {};
        for (int i = 0; i < len; i++) begin
            data.push_back({$urandom, $urandom});
            valid = (i == len - 1) ? nic_pkg::byte_valid_t'(8'hff >> ($urandom % 8)) : 8'hff;
            @(posedge xaui_clk_156_25_out);
            mac_rx <= '{data: data[i], data_valid: valid, good_frame: 1'b0, bad_frame: 1'b0};
        end
        @(posedge xaui_clk_156_25_out);
        mac_rx <= '{data: '0, data_valid: '0, good_frame: good, bad_frame: !good};  // Status
        @(posedge xaui_clk_156_25_out);
        mac_rx <= '0;
    endtask

    // Send a frame, then wait for the writer's outcome pulse
    task automatic run_frame(input int len, input bit good);
        nic_pkg::qword_t    data[$];
        nic_pkg::rx_event_t expected;
        int                 waited;
        send_frame(len, good, data);
        expected = model_frame(data, good);
        waited = 0;
        do begin
            @(posedge xaui_clk_156_25_out);
            waited++;
            assert (waited <= OUTCOME_LIMIT) else begin
                $display("Timeout: the writer gave no outcome pulse for a %0d quadword frame", len);
                stop_with_failure();
            end
        end while (dut_i.rx_event == '0);
        check_value("frame outcome", nic_pkg::qword_t'(expected),
                    nic_pkg::qword_t'(dut_i.rx_event));
    endtask

    //--------------------------------------------------
    // Directed tests
    //--------------------------------------------------
    task automatic test_reset_state();
        test_name = "reset_state";
        expect_state();                        // All zero, rx_ready low
    endtask

    task automatic test_good_frame();
        test_name = "good_frame";
        run_frame(5, 1'b1);
        expect_state();                        // Pointer 5, one good frame
        repeat (5) pop_and_check();
        expect_state();
        pop_and_check();                       // Nothing left
        expect_state();
    endtask

    task automatic test_bad_frame();
        test_name = "bad_frame";
        run_frame(4, 1'b0);
        expect_state();
        pop_and_check();
        expect_state();
    endtask

    task automatic test_avail_cap();
        test_name = "avail_cap";
        run_frame(12, 1'b1);
        run_frame(12, 1'b1);
        expect_reg(nic_pkg::REG_AVAIL, BURST_QWORDS, "REG_AVAIL cap");
        repeat (10) pop_and_check();
        expect_state();                        // 14 left
        while (model_q.size() != 0) pop_and_check();
        expect_state();
    endtask

    task automatic test_overflow();
        test_name = "overflow";
        run_frame(70, 1'b1);                   // Larger than the 63 usable slots
        expect_state();
        run_frame(3, 1'b1);
        expect_state();
        repeat (3) pop_and_check();
        expect_state();
    endtask

    task automatic test_reg_write();
        nic_pkg::qword_t dat;
        test_name = "reg_write";
        wb_cycle(1'b1, nic_pkg::REG_GOOD, {$urandom, $urandom}, dat);
        expect_state();                        // Counter untouched
    endtask

`endif

// ==== tb/tb_nic_rx.sv ====
module tb_nic_rx;

    localparam int BUF_AW       = 6;
    localparam int BURST_QWORDS = 16;
    localparam int MAX_CYCLES   = 4000;        // Tests need well under 1000
    localparam int ACK_LIMIT    = 8;           // Slowest legal ack is 2 cycles
    localparam int OUTCOME_LIMIT = 4;          // Outcome pulse follows the end cycle

    logic             xaui_clk_156_25_out;
    logic             reset_n;
    nic_pkg::mac_rx_t mac_rx;
    nic_pkg::wb_req_t wb_req;
    nic_pkg::wb_rsp_t wb_rsp;
    logic             rx_ready;
    string            test_name;               // Shown in error lines
    int               cycle_count = 0;

    nic_rx_top #(.BUF_AW(BUF_AW), .BURST_QWORDS(BURST_QWORDS)) dut_i (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .mac_rx              (mac_rx),
        .wb_req              (wb_req),
        .wb_rsp              (wb_rsp),
        .rx_ready            (rx_ready)
    );

    function automatic void stop_with_failure();
        $display("Checks failed");
        $fatal(1);
    endfunction

    `include "tb_nic_rx_tasks.svh"

    //--------------------------------------------------
    // Clock and run limit
    //--------------------------------------------------
    initial begin
        xaui_clk_156_25_out = 1'b0;
        forever #50 xaui_clk_156_25_out = ~xaui_clk_156_25_out;  // Period 100
    end

    always @(posedge xaui_clk_156_25_out) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    //--------------------------------------------------
    // Test sequence
    //--------------------------------------------------
    initial begin
        reset_n   = 1'b0;
        mac_rx    = '0;                        // Idle stream
        wb_req    = '0;                        // No bus cycle
        test_name = "reset";
        void'($urandom(26));
        repeat (8) @(posedge xaui_clk_156_25_out);
        reset_n <= 1'b1;

        test_reset_state();
        test_good_frame();
        test_bad_frame();
        test_avail_cap();
        test_overflow();
        test_reg_write();

        $display("All checks passed");
        $finish;
    end

endmodule
